//--- Makefile
# Verilator build and run for the knights_tour core

VERILATOR ?= verilator
TOP       ?= knights_tour_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/10ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+.
knight_cmd_pkg.sv
knight_board_pkg.sv
uart_rx.sv
uart_tx.sv
cmd_proc.sv
knights_tour.sv
knights_tour_props.sv
knights_tour_tb.sv

//--- cmd_proc.sv
`timescale 1ns/10ps
`default_nettype none
`include "knights_params.svh"

module cmd_proc (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire [7:0]                rx_data,
  input  wire                      rx_rdy,
  input  wire                      tx_busy,
  output knight_cmd_pkg::resp_t    tx_data,
  output logic                     trmt,
  output logic                     cal_done,
  output logic                     moving,
  output logic                     piezo,
  output logic                     piezo_n,
  output knight_board_pkg::coord_t xx,
  output knight_board_pkg::coord_t yy
);

  import knight_cmd_pkg::*;
  import knight_board_pkg::*;

  // One shared counter times calibration, each square and the fanfare
  localparam int CNT_W = $clog2(`KT_CAL_CYCLES + `KT_MOVE_CYCLES + `KT_FANFARE_CYCLES);
  localparam logic [CNT_W-1:0] CAL_LAST = CNT_W'(`KT_CAL_CYCLES - 1);
  localparam logic [CNT_W-1:0] MOVE_LAST = CNT_W'(`KT_MOVE_CYCLES - 1);
  localparam logic [CNT_W-1:0] FAN_LAST = CNT_W'(`KT_FANFARE_CYCLES - 1);
  localparam int TONE_W = $clog2(`KT_PIEZO_DIV);
  localparam logic [TONE_W-1:0] TONE_LAST = TONE_W'(`KT_PIEZO_DIV - 1);
  localparam logic signed [5:0] BOARD_LIM = 6'(`KT_BOARD_SIZE);

  typedef enum logic [2:0] {
    CP_IDLE, CP_LOW, CP_DECODE, CP_CAL, CP_TRAVEL, CP_FANFARE, CP_RESP
  } cp_state_t;

  cp_state_t         state;
  logic [7:0]        cmd_hi;
  logic [7:0]        cmd_lo;
  opcode_t           opcode;
  heading_t          heading;
  square_cnt_t       squares;
  dir_t              dir;
  logic              head_ok;
  logic signed [5:0] step;
  logic signed [5:0] tgt_x;
  logic signed [5:0] tgt_y;
  logic              on_board;
  logic              cmd_ok;
  resp_t             resp_q;
  dir_t              dir_q;
  logic              fan_q;
  square_cnt_t       sq_left;
  logic [CNT_W-1:0]  cyc_cnt;
  logic [TONE_W-1:0] tone_cnt;
  logic              square_end;
  logic              reply_due;

  ////////////////////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////////////////////

  assign opcode  = opcode_t'(cmd_hi[7:4]);
  assign heading = heading_t'({cmd_hi[3:0], cmd_lo[7:4]});
  assign squares = cmd_lo[3:0];
  assign step    = $signed({2'b00, squares});

  // Landing square worked out up front, signed so a move off the low edge shows
  always_comb begin
    head_ok = 1'b1;
    dir     = DIR_NORTH;
    tgt_x   = $signed({3'b000, xx});
    tgt_y   = $signed({3'b000, yy});
    case (heading)
      HD_NORTH: tgt_y = tgt_y + step;
      HD_WEST: begin
        dir   = DIR_WEST;
        tgt_x = tgt_x - step;
      end
      HD_SOUTH: begin
        dir   = DIR_SOUTH;
        tgt_y = tgt_y - step;
      end
      HD_EAST: begin
        dir   = DIR_EAST;
        tgt_x = tgt_x + step;
      end
      default: head_ok = 1'b0;
    endcase
  end

  assign on_board = (tgt_x >= 6'sd0) && (tgt_x < BOARD_LIM) &&
                    (tgt_y >= 6'sd0) && (tgt_y < BOARD_LIM);

  // Moves need a calibrated gyro, a known heading and at least one square
  always_comb begin
    case (opcode)
      OP_CAL:               cmd_ok = 1'b1;
      OP_MOVE, OP_MOVE_FAN: cmd_ok = cal_done && head_ok && (squares != '0) && on_board;
      default:              cmd_ok = 1'b0;
    endcase
  end

  assign square_end = (state == CP_TRAVEL) && (cyc_cnt == MOVE_LAST);

  // The reply goes out on the last clock of whatever the command is doing
  // If the transmitter is still busy the FSM parks in CP_RESP instead
  always_comb begin
    case (state)
      CP_DECODE:  reply_due = !cmd_ok;
      CP_CAL:     reply_due = (cyc_cnt == CAL_LAST);
      CP_TRAVEL:  reply_due = square_end && (sq_left == square_cnt_t'(1)) && !fan_q;
      CP_FANFARE: reply_due = (cyc_cnt == FAN_LAST);
      CP_RESP:    reply_due = 1'b1;
      default:    reply_due = 1'b0;
    endcase
  end

  assign trmt    = reply_due && !tx_busy;
  // a reply straight out of decode is always a rejection
  assign tx_data = (state == CP_DECODE) ? RESP_NAK : resp_q;
  assign moving  = (state == CP_TRAVEL);
  assign piezo_n = (state == CP_FANFARE) && !piezo;

  // Command bytes and the decode result held for the rest of the command
  always_ff @(posedge clk) begin
    if (state == CP_IDLE && rx_rdy)
      cmd_hi <= rx_data;
    if (state == CP_LOW && rx_rdy)
      cmd_lo <= rx_data;
    if (state == CP_DECODE) begin
      resp_q <= cmd_ok ? RESP_ACK : RESP_NAK;
      dir_q  <= dir;
      fan_q  <= (opcode == OP_MOVE_FAN);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main FSM, position and calibration flag
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= CP_IDLE;
      cyc_cnt  <= '0;
      sq_left  <= '0;
      cal_done <= 1'b0;
      xx       <= coord_t'(`KT_START_X);
      yy       <= coord_t'(`KT_START_Y);
    end else begin
      cyc_cnt <= cyc_cnt + 1'b1;
      case (state)
        // High byte first, then the low byte completes the command
        CP_IDLE: if (rx_rdy)
          state <= CP_LOW;
        CP_LOW: if (rx_rdy)
          state <= CP_DECODE;
        CP_DECODE: begin
          cyc_cnt <= '0;
          sq_left <= squares;
          if (cmd_ok)
            state <= (opcode == OP_CAL) ? CP_CAL : CP_TRAVEL;
        end
        CP_CAL: if (reply_due)
          cal_done <= 1'b1;
        // Position steps by one as each square of travel finishes
        CP_TRAVEL: if (square_end) begin
          cyc_cnt <= '0;
          sq_left <= sq_left - 1'b1;
          case (dir_q)
            DIR_NORTH: yy <= yy + 1'b1;
            DIR_SOUTH: yy <= yy - 1'b1;
            DIR_EAST:  xx <= xx + 1'b1;
            default:   xx <= xx - 1'b1;
          endcase
          if (sq_left == square_cnt_t'(1) && fan_q)
            state <= CP_FANFARE;
        end
        default: ;
      endcase
      // Finishing a command overrides the per-state next state
      if (reply_due)
        state <= tx_busy ? CP_RESP : CP_IDLE;
    end
  end

  // Tone divider, only runs while the fanfare plays
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tone_cnt <= '0;
      piezo    <= 1'b0;
    end else if (state == CP_FANFARE && !reply_due) begin
      tone_cnt <= tone_cnt + 1'b1;
      if (tone_cnt == TONE_LAST) begin
        tone_cnt <= '0;
        piezo    <= !piezo;
      end
    end else begin
      tone_cnt <= '0;
      piezo    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- knight_board_pkg.sv
`default_nettype none

package knight_board_pkg;

  // One axis of the board, wide enough for squares 0 to 4
  typedef logic [2:0] coord_t;

  // Travel direction once a heading code has been accepted
  typedef enum logic [1:0] {
    DIR_NORTH,
    DIR_WEST,
    DIR_SOUTH,
    DIR_EAST
  } dir_t;

endpackage

`default_nettype wire

//--- knight_cmd_pkg.sv
`default_nettype none

package knight_cmd_pkg;

  // Opcode field in bits 15:12 of the command word
  typedef enum logic [3:0] {
    OP_CAL      = 4'h2,
    OP_MOVE     = 4'h4,
    OP_MOVE_FAN = 4'h5
  } opcode_t;

  // Heading field in bits 11:4
  // North points toward larger y and east toward larger x
  typedef enum logic [7:0] {
    HD_NORTH = 8'h00,
    HD_WEST  = 8'h3F,
    HD_SOUTH = 8'h7F,
    HD_EAST  = 8'hBF
  } heading_t;

  // Number of squares to travel, bits 3:0
  typedef logic [3:0] square_cnt_t;

  // One byte goes back to the remote after every command
  typedef enum logic [7:0] {
    RESP_ACK = 8'hA5,
    RESP_NAK = 8'h5A
  } resp_t;

endpackage

`default_nettype wire

//--- knights_params.svh
`ifndef KNIGHTS_PARAMS_SVH
`define KNIGHTS_PARAMS_SVH

// Clocks per serial bit on both UART directions
`define KT_BAUD_DIV 16

// Gyro calibration stands in as a fixed wait of this many clocks
`define KT_CAL_CYCLES 200

// Travel time for one square of a leg move
`define KT_MOVE_CYCLES 300

// Length of the tune played after a fanfare move
`define KT_FANFARE_CYCLES 400

// Half period of the piezo tone
`define KT_PIEZO_DIV 8

// Board is square, KT_BOARD_SIZE squares per side
`define KT_BOARD_SIZE 5

// The knight starts on the center square
`define KT_START_X 2
`define KT_START_Y 2

`endif

//--- knights_tour.sv
`timescale 1ns/10ps
`default_nettype none

module knights_tour (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           rx,
  output wire                           tx,
  output wire                           cal_done,
  output wire                           moving,
  output wire                           piezo,
  output wire                           piezo_n,
  output wire knight_board_pkg::coord_t xx,
  output wire knight_board_pkg::coord_t yy
);

  import knight_cmd_pkg::*;

  // Received bytes toward the command processor
  logic [7:0] rx_data;
  logic       rx_rdy;

  // Response byte and its strobe back out to the remote
  resp_t      tx_data;
  logic       trmt;
  logic       tx_busy;

  uart_rx uart_rx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_data (rx_data),
    .rx_rdy  (rx_rdy)
  );

  // Decode, timers and board position all live here
  cmd_proc cmd_proc_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_data  (rx_data),
    .rx_rdy   (rx_rdy),
    .tx_busy  (tx_busy),
    .tx_data  (tx_data),
    .trmt     (trmt),
    .cal_done (cal_done),
    .moving   (moving),
    .piezo    (piezo),
    .piezo_n  (piezo_n),
    .xx       (xx),
    .yy       (yy)
  );

  uart_tx uart_tx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_data (tx_data),
    .trmt    (trmt),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

endmodule

`default_nettype wire

//--- knights_tour_props.sv
`timescale 1ns/10ps
`default_nettype none
`include "knights_params.svh"

module knights_tour_props (
  input wire                           clk,
  input wire                           rst_n,
  input wire                           cal_done,
  input wire                           moving,
  input wire                           piezo,
  input wire                           trmt,
  input wire                           tx_busy,
  input wire knight_board_pkg::coord_t xx,
  input wire knight_board_pkg::coord_t yy
);

  // Count of assertion failures, read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Travel is only allowed once the gyro is calibrated
  moving_needs_cal: assert property (@(posedge clk) disable iff (!rst_n)
    moving |-> cal_done)
  else begin
    $error("moving is high while cal_done is low");
    fail_count++;
  end

  // The tune only plays after the last square, never during travel
  quiet_while_moving: assert property (@(posedge clk) disable iff (!rst_n)
    moving |-> !piezo)
  else begin
    $error("piezo is high while the knight is moving");
    fail_count++;
  end

  // Position never leaves the board
  pos_on_board: assert property (@(posedge clk) disable iff (!rst_n)
    (xx < 3'(`KT_BOARD_SIZE)) && (yy < 3'(`KT_BOARD_SIZE)))
  else begin
    $error("position xx=%0d yy=%0d is off the board", xx, yy);
    fail_count++;
  end

  // A reply strobe must find the transmitter idle, so busy rises right after it
  no_trmt_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    trmt |=> $rose(tx_busy))
  else begin
    $error("trmt was not taken by an idle transmitter");
    fail_count++;
  end

endmodule

bind cmd_proc knights_tour_props knights_tour_props_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .cal_done (cal_done),
  .moving   (moving),
  .piezo    (piezo),
  .trmt     (trmt),
  .tx_busy  (tx_busy),
  .xx       (xx),
  .yy       (yy)
);

`default_nettype wire

//--- knights_tour_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "knights_params.svh"

module knights_tour_tb;

  import knight_cmd_pkg::*;
  import knight_board_pkg::*;

  localparam int BIT_CLKS = `KT_BAUD_DIV;
  localparam int RESP_TIMEOUT = 5000;
  localparam int NUM_DIRECTED = 9;
  localparam int NUM_RANDOM = 12;

  // One directed step: command word, reply byte, final square and fanfare flag
  typedef struct packed {
    logic [15:0] cmd;
    resp_t       resp;
    coord_t      x;
    coord_t      y;
    logic        fan;
  } entry_t;

  logic   clk;
  logic   rst_n;
  logic   rx;
  wire    tx;
  wire    cal_done;
  wire    moving;
  wire    piezo;
  wire    piezo_n;
  coord_t xx;
  coord_t yy;

  entry_t cmd_table [0:NUM_DIRECTED-1];
  integer seed;
  logic   cal_model;
  int     model_x;
  int     model_y;

  knights_tour knights_tour_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .tx       (tx),
    .cal_done (cal_done),
    .moving   (moving),
    .piezo    (piezo),
    .piezo_n  (piezo_n),
    .xx       (xx),
    .yy       (yy)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  //////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    abort_run();
  endtask

  task automatic check_resp(input resp_t exp, input resp_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t signal=tx_data expected=%h actual=%h",
               $time, exp, act);
      abort_run();
    end
  endtask

  task automatic check_coord(input string name, input coord_t exp, input coord_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
               $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
               $time, name, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Serial driver and monitor
  //////////////////////////////////////////////////////////////////////////

  // Start bit, eight data bits LSB first, stop bit, each held BIT_CLKS clocks
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    int         i;
    int         k;
    frame = {1'b1, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[i];
      for (k = 1; k < BIT_CLKS; k++)
        @(posedge clk);
    end
  endtask

  task automatic wait_bit_times(input int clks);
    int k;
    for (k = 0; k < clks; k++)
      @(negedge clk);
  endtask

  // Watches moving and piezo until the reply starts, then decodes it mid-bit
  // A fanfare cycle is one where exactly one of piezo and piezo_n is high
  task automatic wait_response(output resp_t byte_got, output logic saw_moving,
                               output int toggles, output int fan_cycles);
    logic [7:0] data;
    logic       last_piezo;
    int         cnt;
    int         i;
    data       = '0;
    saw_moving = 1'b0;
    toggles    = 0;
    fan_cycles = 0;
    @(negedge clk);
    last_piezo = piezo;
    for (cnt = 0; cnt < RESP_TIMEOUT && tx !== 1'b0; cnt++) begin
      if (moving === 1'b1)
        saw_moving = 1'b1;
      if (piezo !== last_piezo)
        toggles++;
      if ((piezo ^ piezo_n) === 1'b1)
        fan_cycles++;
      last_piezo = piezo;
      @(negedge clk);
    end
    if (tx !== 1'b0) begin
      report_error("timeout, the start bit of the response byte never came");
    end else begin
      wait_bit_times(BIT_CLKS / 2);
      if (tx !== 1'b0)
        report_error("the response start bit ended before its middle");
      for (i = 0; i < 8; i++) begin
        wait_bit_times(BIT_CLKS);
        data[i] = tx;
      end
      wait_bit_times(BIT_CLKS);
      if (tx !== 1'b1)
        report_error("the stop bit of the response byte was low");
    end
    byte_got = resp_t'(data);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Command runner and reference model
  //////////////////////////////////////////////////////////////////////////

  task automatic run_cmd(input logic [15:0] cmd, input resp_t exp_resp,
                         input coord_t exp_x, input coord_t exp_y, input logic fan);
    resp_t got;
    logic  saw_moving;
    int    toggles;
    int    fan_cycles;
    int    exp_fan;
    logic  is_move;
    is_move = (cmd[15:12] == 4'h4) || (cmd[15:12] == 4'h5);
    exp_fan = (fan && exp_resp == RESP_ACK) ? `KT_FANFARE_CYCLES : 0;
    send_byte(cmd[15:8]);
    // One idle bit between the two bytes of a command
    wait_bit_times(BIT_CLKS);
    send_byte(cmd[7:0]);
    wait_response(got, saw_moving, toggles, fan_cycles);
    check_resp(exp_resp, got);
    check_coord("xx", exp_x, xx);
    check_coord("yy", exp_y, yy);
    check_bit("moving during the command", is_move && exp_resp == RESP_ACK, saw_moving);
    check_bit("piezo toggling", fan && exp_resp == RESP_ACK, toggles >= 2);
    check_bit("piezo_n opposite piezo for the fanfare", 1'b1, fan_cycles == exp_fan);
    check_bit("piezo after the command", 1'b0, piezo);
    check_bit("piezo_n after the command", 1'b0, piezo_n);
    if (cmd[15:12] == 4'h2)
      cal_model = 1'b1;
    check_bit("cal_done", cal_model, cal_done);
    model_x = int'(exp_x);
    model_y = int'(exp_y);
  endtask

  // Predicts the reply and landing square from the command word alone
  function automatic void predict_cmd(input logic [15:0] cmd, input logic cal,
                                      input int x, input int y, output resp_t resp,
                                      output int nx, output int ny);
    int dx;
    int dy;
    int n;
    dx   = 0;
    dy   = 0;
    n    = int'(cmd[3:0]);
    nx   = x;
    ny   = y;
    resp = RESP_NAK;
    case (cmd[11:4])
      8'h00:   dy = 1;
      8'h3F:   dx = -1;
      8'h7F:   dy = -1;
      8'hBF:   dx = 1;
      default: ;
    endcase
    if (cmd[15:12] == 4'h2) begin
      resp = RESP_ACK;
    end else if ((cmd[15:12] == 4'h4 || cmd[15:12] == 4'h5) && cal &&
                 (dx != 0 || dy != 0) && n != 0 &&
                 x + dx * n >= 0 && x + dx * n < `KT_BOARD_SIZE &&
                 y + dy * n >= 0 && y + dy * n < `KT_BOARD_SIZE) begin
      resp = RESP_ACK;
      nx   = x + dx * n;
      ny   = y + dy * n;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [3:0]  opc;
    logic [7:0]  hd;
    logic [3:0]  cnt;
    logic [15:0] cmd;
    resp_t       exp_r;
    int          nx;
    int          ny;
    int          i;
    clk       = 1'b0;
    rst_n     = 1'b0;
    rx        = 1'b1;
    seed      = 81;
    cal_model = 1'b0;
    model_x   = `KT_START_X;
    model_y   = `KT_START_Y;

    // Before calibration, calibrate, then legal and illegal moves
    cmd_table[0] = '{16'h4001, RESP_NAK, 3'd2, 3'd2, 1'b0};
    cmd_table[1] = '{16'h2000, RESP_ACK, 3'd2, 3'd2, 1'b0};
    cmd_table[2] = '{16'h43F2, RESP_ACK, 3'd0, 3'd2, 1'b0};
    cmd_table[3] = '{16'h5001, RESP_ACK, 3'd0, 3'd3, 1'b1};
    cmd_table[4] = '{16'h43F1, RESP_NAK, 3'd0, 3'd3, 1'b0};
    cmd_table[5] = '{16'h4123, RESP_NAK, 3'd0, 3'd3, 1'b0};
    cmd_table[6] = '{16'h4BF0, RESP_NAK, 3'd0, 3'd3, 1'b0};
    cmd_table[7] = '{16'h7001, RESP_NAK, 3'd0, 3'd3, 1'b0};
    cmd_table[8] = '{16'h4BF2, RESP_ACK, 3'd2, 3'd3, 1'b0};

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("tx", 1'b1, tx);
    check_bit("cal_done", 1'b0, cal_done);
    check_bit("moving", 1'b0, moving);
    check_bit("piezo", 1'b0, piezo);
    check_bit("piezo_n", 1'b0, piezo_n);
    check_coord("xx", coord_t'(`KT_START_X), xx);
    check_coord("yy", coord_t'(`KT_START_Y), yy);

    for (i = 0; i < NUM_DIRECTED; i++)
      run_cmd(cmd_table[i].cmd, cmd_table[i].resp, cmd_table[i].x,
              cmd_table[i].y, cmd_table[i].fan);

    // Random moves from wherever the directed part left the knight
    for (i = 0; i < NUM_RANDOM; i++) begin
      r   = $random(seed);
      opc = r[0] ? 4'h5 : 4'h4;
      case (r[2:1])
        2'd0:    hd = 8'h00;
        2'd1:    hd = 8'h3F;
        2'd2:    hd = 8'h7F;
        default: hd = 8'hBF;
      endcase
      cnt = {2'b00, r[4:3]} + 4'd1;
      cmd = {opc, hd, cnt};
      predict_cmd(cmd, cal_model, model_x, model_y, exp_r, nx, ny);
      run_cmd(cmd, exp_r, coord_t'(nx), coord_t'(ny), opc == 4'h5);
    end

    if (knights_tour_inst.cmd_proc_inst.knights_tour_props_inst.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "Assertion failures were reported during the run");
    end
  end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/10ps
`default_nettype none
`include "knights_params.svh"

module uart_rx (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  output logic [7:0] rx_data,
  output logic       rx_rdy
);

  localparam int BAUD_DIV = `KT_BAUD_DIV;
  localparam int CNT_W = $clog2(BAUD_DIV);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BAUD_DIV / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(BAUD_DIV - 1);

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_TAIL} rx_state_t;

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] baud_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shift_reg;

  // Two flops bring the line into the clock domain
  // Both come out of reset high so an idle line is not taken as a start bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bit timing FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_rdy   <= 1'b0;
    end else begin
      rx_rdy   <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (!rx_sync)
            state <= RX_START;
        end
        // Recheck the line halfway into the start bit to reject glitches
        RX_START: if (baud_cnt == HALF_LAST) begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          state    <= rx_sync ? RX_IDLE : RX_DATA;
        end
        // From here on every full bit period lands on a bit center
        RX_DATA: if (baud_cnt == FULL_LAST) begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7)
            state <= RX_STOP;
        end
        // A low stop bit is a framing error and the byte is thrown away
        RX_STOP: if (baud_cnt == FULL_LAST) begin
          baud_cnt <= '0;
          state    <= rx_sync ? RX_TAIL : RX_IDLE;
        end
        // Hold off to the end of the stop bit, then flag the byte
        default: if (baud_cnt == HALF_LAST) begin
          rx_rdy <= 1'b1;
          state  <= RX_IDLE;
        end
      endcase
    end
  end

  // Data arrives LSB first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && baud_cnt == FULL_LAST)
      shift_reg <= {rx_sync, shift_reg[7:1]};
  end

  assign rx_data = shift_reg;

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/10ps
`default_nettype none
`include "knights_params.svh"

module uart_tx (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire knight_cmd_pkg::resp_t tx_data,
  input  wire                   trmt,
  output logic                  tx,
  output logic                  tx_busy
);

  localparam int BAUD_DIV = `KT_BAUD_DIV;
  localparam int CNT_W = $clog2(BAUD_DIV);
  localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(BAUD_DIV - 1);

  logic [9:0]       shift_reg;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;

  // Frame is start bit, eight data bits LSB first, stop bit
  // Ones are shifted in behind the frame so the line rests high afterwards
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_reg <= '1;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      tx_busy   <= 1'b0;
    end else if (trmt && !tx_busy) begin
      shift_reg <= {1'b1, tx_data, 1'b0};
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      tx_busy   <= 1'b1;
    end else if (tx_busy) begin
      if (baud_cnt == FULL_LAST) begin
        baud_cnt  <= '0;
        shift_reg <= {1'b1, shift_reg[9:1]};
        bit_cnt   <= bit_cnt + 1'b1;
        // Busy drops as the stop bit period runs out
        if (bit_cnt == 4'd9)
          tx_busy <= 1'b0;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // The line is the low end of the shift register, no extra flop needed
  assign tx = shift_reg[0];

endmodule

`default_nettype wire
